/* Bender.yml */
package:
  name: tt_um_parallellogic_regmap

sources:
  - include_dirs:
      - design
    files:
      - design/regmap_pkg.sv
      - design/spi_target.sv
      - design/reg_file.sv
      - design/lfsr_counter.sv
      - design/output_mux.sv
      - design/tt_um_parallellogic_regmap.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/tb_regmap.sv

/* all.f */
+incdir+design
design/regmap_pkg.sv
design/spi_target.sv
design/reg_file.sv
design/lfsr_counter.sv
design/output_mux.sv
design/tt_um_parallellogic_regmap.sv
verif/tb_regmap.sv

/* design/lfsr_counter.sv */
`include "regmap_settings.svh"

module lfsr_counter import regmap_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   clear,    // hold at seed while high
  input  logic   is_lfsr,  // 1 lfsr, 0 binary count
  output count_t count
);

  logic   feedback;
  count_t next_count;

  // fibonacci taps 16 15 13 4
  assign feedback = count[15] ^ count[14] ^ count[12] ^ count[3];

  always_comb begin
    if (is_lfsr) begin
      next_count = {count[14:0], feedback};  // shift left, feedback into bit 0
    end else begin
      next_count = count + 16'd1;
    end
  end

  // mode change carries on from the current value
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      count <= `LFSR_SEED;
    end else begin
      count <= next_count;
    end
  end

endmodule

/* design/output_mux.sv */
`include "regmap_settings.svh"

module output_mux import regmap_pkg::*; (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [4:0]                 gen_in,    // ui_in[7:3], raw
  input  logic                       mosi,
  input  logic                       sclk,
  input  reg_byte_t                  inv_mask,  // bits 2:0 unused, spi pins not inverted
  input  logic [`RW_REG_COUNT*8-1:0] all_regs,
  input  count_t                     count,
  input  logic [3:0]                 dim_tap,   // counter bit used as pwm
  input  mux_sel_t                   view_sel,
  output pin_view_t                  pin_view
);

  localparam int IDX_W = $clog2(`RW_REG_COUNT);

  logic [4:0]       gen_inv;
  logic [IDX_W-1:0] dec_idx;
  pin_view_t        echo;
  pin_view_t        decode;
  pin_view_t        next_view;

  assign gen_inv = gen_in ^ inv_mask[7:3];
  assign dec_idx = gen_inv[4 -: IDX_W];             // ui_in[7:5] after inversion
  assign decode  = all_regs[dec_idx*8 +: 7];        // low 7 bits of the picked reg
  assign echo    = {gen_inv, mosi, sclk};           // asic_in, ui_in[3], mosi, sclk

  always_comb begin
    case (view_sel)
      2'd0:    next_view = echo;
      2'd1:    next_view = decode;
      2'd2:    next_view = count[6:0];
      default: next_view = decode & {7{count[dim_tap]}};  // dimmed decode
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pin_view <= '0;
    end else begin
      pin_view <= next_view;
    end
  end

endmodule

/* design/reg_file.sv */
`include "regmap_settings.svh"

module reg_file import regmap_pkg::*; (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         wr_strobe,
  input  reg_addr_t                    wr_addr,
  input  reg_addr_t                    rd_addr,
  input  reg_byte_t                    wr_data,
  output reg_byte_t                    rd_data,   // combinational
  output reg_byte_t                    ctrl,
  output reg_byte_t                    inv_mask,
  output logic [`RW_REG_COUNT*8-1:0]   all_regs   // reg 0 in the low byte
);

  localparam int IDX_W = $clog2(`RW_REG_COUNT);

  reg_byte_t regs [`RW_REG_COUNT];

  // single writer, the spi target
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RW_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_strobe && wr_addr < `RW_REG_COUNT) begin
      regs[wr_addr[IDX_W-1:0]] <= wr_data;  // id byte and holes ignore writes
    end
  end

  // read mux, rw block then identity then zeros
  always_comb begin
    if (rd_addr < `RW_REG_COUNT) begin
      rd_data = regs[rd_addr[IDX_W-1:0]];
    end else if (rd_addr < `RO_ID_ADDR + `RO_REG_COUNT) begin
      rd_data = `ID_BYTE;
    end else begin
      rd_data = '0;
    end
  end

  always_comb begin
    for (int i = 0; i < `RW_REG_COUNT; i++) begin
      all_regs[i*8 +: 8] = regs[i];  // flat for the decode views
    end
  end

  assign ctrl     = regs[`REG_CTRL];
  assign inv_mask = regs[`REG_INV];

endmodule

/* design/regmap_pkg.sv */
package regmap_pkg;

  typedef logic [7:0]  reg_byte_t;  // one config byte
  typedef logic [4:0]  reg_addr_t;  // address field of the spi command byte
  typedef logic [15:0] count_t;     // free-running counter value
  typedef logic [6:0]  pin_view_t;  // uo_out[6:0], miso takes bit 7
  typedef logic [1:0]  mux_sel_t;   // one of four output views

  // spi byte framing
  typedef enum logic [1:0] {
    IDLE,  // cs high, waiting for a frame
    CMD,   // shifting in the command byte
    DATA,  // data byte, in on mosi or out on miso
    DONE   // 16 bits seen, wait for cs to rise
  } spi_state_t;

endpackage

/* design/regmap_settings.svh */
`ifndef REGMAP_SETTINGS_SVH
`define REGMAP_SETTINGS_SVH

// register map layout
`define RW_REG_COUNT 8       // read-write config bytes
`define RO_REG_COUNT 1       // read-only bytes after the rw block
`define REG_CTRL     6       // clear, lfsr, view select, dim tap
`define REG_INV      7       // input inversion mask
`define RO_ID_ADDR   8       // identity byte lives here

`define ID_BYTE      8'hE5   // tile identity
`define LFSR_SEED    16'h0001 // nonzero so the lfsr never locks up

`define SYNC_STAGES  2       // flops per spi pin synchronizer

`endif

/* design/spi_target.sv */
`include "regmap_settings.svh"

module spi_target import regmap_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      spi_cs,     // active low
  input  logic      spi_clk,
  input  logic      spi_mosi,
  input  reg_byte_t rd_data,    // byte at rd_addr, from the register file
  output logic      spi_miso,
  output logic      wr_strobe,  // single cycle, completed write frames only
  output reg_addr_t wr_addr,
  output reg_addr_t rd_addr,    // valid from the end of byte 1
  output reg_byte_t wr_data
);

  logic [`SYNC_STAGES-1:0] cs_sync;
  logic [`SYNC_STAGES-1:0] mosi_sync;
  logic [`SYNC_STAGES:0]   sclk_sync;   // extra stage keeps the previous level
  logic                    cs_n_s;
  logic                    mosi_s;
  logic                    sclk_rise;
  logic                    sclk_fall;
  spi_state_t              state;
  logic [3:0]              bit_cnt;     // rising edges seen in this frame
  logic                    cmd_write;   // write flag of byte 1
  reg_addr_t               cmd_addr;
  reg_byte_t               rx_shift;
  reg_byte_t               tx_shift;

  // pin synchronizers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cs_sync   <= '1;  // deselected
      mosi_sync <= '0;
      sclk_sync <= '0;
    end else begin
      cs_sync   <= {cs_sync[`SYNC_STAGES-2:0], spi_cs};
      mosi_sync <= {mosi_sync[`SYNC_STAGES-2:0], spi_mosi};
      sclk_sync <= {sclk_sync[`SYNC_STAGES-1:0], spi_clk};
    end
  end

  assign cs_n_s    = cs_sync[`SYNC_STAGES-1];
  assign mosi_s    = mosi_sync[`SYNC_STAGES-1];
  assign sclk_rise = sclk_sync[`SYNC_STAGES-1] & ~sclk_sync[`SYNC_STAGES];
  assign sclk_fall = ~sclk_sync[`SYNC_STAGES-1] & sclk_sync[`SYNC_STAGES];

  // frame FSM, cs high anywhere aborts without a write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= IDLE;
      bit_cnt   <= '0;
      cmd_write <= 1'b0;
      tx_shift  <= '0;
      wr_strobe <= 1'b0;
    end else begin
      wr_strobe <= 1'b0;                         // pulse only
      case (state)
        IDLE: begin
          bit_cnt  <= '0;
          tx_shift <= '0;                        // miso low outside byte 2
          if (!cs_n_s) state <= CMD;
        end
        CMD: begin
          if (cs_n_s) begin
            state <= IDLE;
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd7) begin           // 8th bit, command complete
              cmd_write <= rx_shift[6];          // msb of byte 1
              state     <= DATA;
            end
          end
        end
        DATA: begin
          if (cs_n_s) begin
            state <= IDLE;
          end else if (sclk_rise) begin
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd15) begin          // last bit of the frame
              wr_strobe <= cmd_write;
              state     <= DONE;
            end
          end else if (sclk_fall && !cmd_write) begin
            if (bit_cnt == 4'd8) begin
              tx_shift <= rd_data;               // msb out before first data rise
            end else begin
              tx_shift <= {tx_shift[6:0], 1'b0}; // next bit on each fall
            end
          end
        end
        DONE: begin
          tx_shift <= '0;
          if (cs_n_s) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // shift data path
  always_ff @(posedge clk) begin
    if (sclk_rise) rx_shift <= {rx_shift[6:0], mosi_s};  // msb first
    if (state == CMD && sclk_rise && bit_cnt == 4'd7) begin
      cmd_addr <= {rx_shift[3:0], mosi_s};              // bits 4:0 of byte 1
    end
    if (state == DATA && sclk_rise && bit_cnt == 4'd15) begin
      wr_data <= {rx_shift[6:0], mosi_s};
    end
  end

  assign spi_miso = tx_shift[7];
  assign wr_addr  = cmd_addr;
  assign rd_addr  = cmd_addr;

endmodule

/* design/tt_um_parallellogic_regmap.sv */
`include "regmap_settings.svh"

module tt_um_parallellogic_regmap import regmap_pkg::*; (
  input  logic [7:0] ui_in,    // cs, sclk, mosi, then general inputs
  output logic [7:0] uo_out,   // view on 6:0, miso on 7
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe,
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n     // sync, active low
);

  logic                       miso;
  logic                       wr_strobe;
  reg_addr_t                  wr_addr;
  reg_addr_t                  rd_addr;
  reg_byte_t                  wr_data;
  reg_byte_t                  rd_data;
  reg_byte_t                  ctrl;      // clear, lfsr, view select, dim tap
  reg_byte_t                  inv_mask;
  logic [`RW_REG_COUNT*8-1:0] all_regs;
  count_t                     count;
  pin_view_t                  pin_view;

  spi_target spi_target_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi_cs    (ui_in[0]),
    .spi_clk   (ui_in[1]),
    .spi_mosi  (ui_in[2]),
    .rd_data   (rd_data),
    .spi_miso  (miso),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .wr_data   (wr_data)
  );

  reg_file reg_file_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .wr_data   (wr_data),
    .rd_data   (rd_data),
    .ctrl      (ctrl),
    .inv_mask  (inv_mask),
    .all_regs  (all_regs)
  );

  lfsr_counter lfsr_counter_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (ctrl[7]),
    .is_lfsr (ctrl[6]),
    .count   (count)
  );

  output_mux output_mux_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .gen_in   (ui_in[7:3]),
    .mosi     (ui_in[2]),
    .sclk     (ui_in[1]),
    .inv_mask (inv_mask),
    .all_regs (all_regs),
    .count    (count),
    .dim_tap  (ctrl[3:0]),
    .view_sel (ctrl[5:4]),
    .pin_view (pin_view)
  );

  assign uo_out  = {miso, pin_view};
  assign uio_out = '0;
  assign uio_oe  = '0;  // bidir pins all inputs

endmodule

/* verif/tb_regmap.sv */
`include "regmap_settings.svh"

module tb_regmap import regmap_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_SCLK = 8;    // clk cycles per sclk half period
  localparam int N_WRITES  = 40;   // random write frames
  localparam int N_ABORTS  = 8;
  localparam int N_VIEWS   = 12;   // echo and decode rounds
  localparam int N_FRAMES  = 18 + 3*N_WRITES + 2*N_ABORTS + 3*N_VIEWS + 7;
  localparam int TIMEOUT_CYCLES = N_FRAMES*300 + 2000;  // a frame is under 300 cycles

  logic       clk;
  logic       rst_n;
  logic       cs;        // active low
  logic       sclk;
  logic       mosi;
  logic [4:0] gen_in;    // ui_in[7:3]
  logic [7:0] uio_in;
  logic       ena;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;
  reg_byte_t  model [`RW_REG_COUNT];  // mirror of the rw registers
  string      test_name;

  tt_um_parallellogic_regmap dut_i (
    .ui_in   ({gen_in, mosi, sclk, cs}),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  always #20 clk = ~clk;  // 40 ns period

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string what, input reg_byte_t exp, input reg_byte_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s %s: expected %02h actual %02h", test_name, what, exp, act));
    end
  endtask

  task automatic check_view(input string what, input pin_view_t exp, input pin_view_t act);
    if (act !== exp) begin
      fail_run($sformatf("ERR %s %s: expected %02h actual %02h", test_name, what, exp, act));
    end
  endtask

  // read rule of the map: rw block, identity, then zeros
  function automatic reg_byte_t expected_read(input reg_addr_t addr);
    if (addr < `RW_REG_COUNT) return model[addr];
    if (addr == `RO_ID_ADDR) return `ID_BYTE;
    return 8'h00;
  endfunction

  function automatic pin_view_t echo_of(input logic [4:0] gen, input reg_byte_t inv);
    return {gen ^ inv[7:3], mosi, sclk};
  endfunction

  function automatic pin_view_t decode_of(input logic [4:0] gen, input reg_byte_t inv);
    logic [4:0] g;
    g = gen ^ inv[7:3];
    return model[g[4:2]][6:0];  // top three inverted bits pick the register
  endfunction

  // one mode 0 bit, starts and ends on a rising clk edge
  task automatic spi_bit(input logic b, output logic miso_bit);
    sclk <= 1'b0;
    mosi <= b;                             // data set up while sclk low
    repeat (HALF_SCLK-1) @(posedge clk);
    @(negedge clk);
    miso_bit = uo_out[7];                  // stable since the last fall
    @(posedge clk);
    sclk <= 1'b1;
    repeat (HALF_SCLK) @(posedge clk);
  endtask

  // nbits below 16 cuts the frame short with cs
  task automatic spi_frame(input reg_byte_t cmd, input reg_byte_t data, input int nbits,
                           output reg_byte_t rx);
    logic [15:0] word;
    logic        mbit;
    word = {cmd, data};
    rx   = 8'h00;
    @(posedge clk);
    cs <= 1'b0;
    repeat (HALF_SCLK) @(posedge clk);
    for (int i = 0; i < nbits; i++) begin
      spi_bit(word[15-i], mbit);
      if (i < 8 && mbit !== 1'b0) fail_run("miso was not low during the command byte");
      if (i >= 8) rx = {rx[6:0], mbit};    // byte 2 on miso
    end
    sclk <= 1'b0;
    mosi <= 1'b0;
    repeat (HALF_SCLK) @(posedge clk);
    cs <= 1'b1;
    repeat (HALF_SCLK) @(posedge clk);
  endtask

  task automatic spi_write(input reg_addr_t addr, input reg_byte_t data);
    reg_byte_t dummy;
    spi_frame({1'b1, 2'b00, addr}, data, 16, dummy);
    if (addr < `RW_REG_COUNT) model[addr] = data;  // holes and id ignore writes
  endtask

  task automatic spi_read(input reg_addr_t addr, output reg_byte_t data);
    spi_frame({1'b0, 2'b00, addr}, 8'h00, 16, data);
  endtask

  task automatic read_check(input reg_addr_t addr);
    reg_byte_t got;
    spi_read(addr, got);
    check_byte($sformatf("read of addr %0d", addr), expected_read(addr), got);
  endtask

  task automatic set_gen(input logic [4:0] val);
    @(posedge clk);
    gen_in <= val;
  endtask

  task automatic settle_view(output pin_view_t v);
    repeat (10) @(posedge clk);
    @(negedge clk);
    v = uo_out[6:0];
  endtask

  initial begin
    pin_view_t   v;
    pin_view_t   prev;
    reg_byte_t   data;
    reg_byte_t   rx_byte;
    reg_byte_t   inv;
    reg_addr_t   addr;
    int          tap;
    int          n_on;
    int          n_off;
    int unsigned seed_val;
    seed_val  = $urandom(32'h946e_e8bf);  // only seeding call
    test_name = "reset_and_identity";
    clk       = 1'b0;
    rst_n     = 1'b0;
    cs        = 1'b1;
    sclk      = 1'b0;
    mosi      = 1'b0;
    ena       = 1'b1;
    uio_in    = 8'h00;
    gen_in    = 5'($urandom);
    for (int i = 0; i < `RW_REG_COUNT; i++) model[i] = 8'h00;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    settle_view(v);
    check_view("echo after reset", echo_of(gen_in, 8'h00), v);
    if (uo_out[7] !== 1'b0) fail_run("miso is not low after reset");
    if (uio_out !== 8'h00 || uio_oe !== 8'h00) fail_run("bidirectional pins are not tied off");
    read_check(`RO_ID_ADDR);
    for (int i = 0; i < `RW_REG_COUNT; i++) read_check(reg_addr_t'(i));

    test_name = "random_write_read";
    for (int i = 0; i < N_WRITES; i++) begin
      if ($urandom_range(0, 3) == 0) addr = reg_addr_t'($urandom_range(9, 31));
      else addr = reg_addr_t'($urandom_range(0, 5));
      spi_write(addr, reg_byte_t'($urandom));
      read_check(addr);
      read_check(reg_addr_t'($urandom_range(0, 8)));
    end
    for (int i = 0; i <= `RO_ID_ADDR; i++) read_check(reg_addr_t'(i));

    test_name = "aborted_frame";
    for (int i = 0; i < N_ABORTS; i++) begin
      addr = reg_addr_t'($urandom_range(0, 5));
      data = model[addr] ^ reg_byte_t'($urandom_range(1, 255));  // differs from stored
      spi_frame({1'b1, 2'b00, addr}, data, $urandom_range(1, 15), rx_byte);
      read_check(addr);
    end

    test_name = "echo_and_decode";
    for (int i = 0; i < N_VIEWS; i++) begin
      inv = reg_byte_t'($urandom);
      spi_write(`REG_INV, inv);
      spi_write(`REG_CTRL, 8'h00);          // view 0
      set_gen(5'($urandom));
      mosi <= 1'($urandom);                 // spi lines are free while cs is high
      sclk <= 1'($urandom);
      settle_view(v);
      check_view("echo view", echo_of(gen_in, inv), v);
      @(posedge clk);
      mosi <= 1'b0;
      sclk <= 1'b0;
      spi_write(`REG_CTRL, 8'h10);          // view 1
      set_gen(5'($urandom));
      settle_view(v);
      check_view("decode view", decode_of(gen_in, inv), v);
    end

    test_name = "counter_modes";
    spi_write(`REG_CTRL, 8'hA0);            // clear held, view 2
    settle_view(v);
    check_view("cleared counter", 7'h01, v);
    spi_write(`REG_CTRL, 8'h20);            // binary count
    settle_view(prev);
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      v = uo_out[6:0];
      check_view("binary step", prev + 7'd1, v);
      prev = v;
    end
    spi_write(`REG_CTRL, 8'hE0);            // clear in lfsr mode
    spi_write(`REG_CTRL, 8'h60);
    settle_view(prev);
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      v = uo_out[6:0];
      check_view("lfsr shift", {prev[5:0], v[0]}, v);  // bit 0 is the feedback
      prev = v;
    end

    test_name = "dimmed_view";
    spi_write(5'd0, reg_byte_t'($urandom) | 8'h01);  // nonzero low bits
    spi_write(`REG_INV, 8'h00);
    tap = $urandom_range(0, 4);
    spi_write(`REG_CTRL, 8'h30 | reg_byte_t'(tap));  // view 3
    set_gen({3'b000, 2'($urandom)});        // index 0
    settle_view(v);
    n_on  = 0;
    n_off = 0;
    for (int i = 0; i < 64; i++) begin
      @(negedge clk);
      v = uo_out[6:0];
      if (v == decode_of(gen_in, 8'h00)) n_on++;
      else if (v == 7'h00) n_off++;
      else check_view("dim sample", decode_of(gen_in, 8'h00), v);
    end
    if (n_on == 0 || n_off == 0) fail_run("dimmed view did not show both on and off samples");

    $display("Everything OK");
    $finish;
  end

  // bounded by the frame budget
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $fatal(1, "watchdog expired");
  end

endmodule
